/* compile.f */
logic/alu_pkg.sv
logic/rv_isa_pkg.sv
logic/add_sub_unit.sv
logic/alu.sv
logic/pipe_reg.sv
logic/instr_decoder.sv
logic/result_select.sv
logic/exec_unit.sv
test/exec_unit_properties.sv
test/exec_unit_tb.sv

/* logic/add_sub_unit.sv */
`timescale 1ns/1ps

module add_sub_unit #(
    parameter int XLEN = 32
) (
    input  logic            sub,
    input  logic [XLEN-1:0] x,
    input  logic [XLEN-1:0] y,
    output logic [XLEN-1:0] sum,
    output logic            overflow
);
    logic [XLEN-1:0] y_eff;

    // x - y as x + ~y + 1
    assign y_eff = sub ? ~y : y;
    assign sum   = x + y_eff + XLEN'(sub);

    // same-sign inputs, different-sign result
    assign overflow = (x[XLEN-1] == y_eff[XLEN-1]) && (sum[XLEN-1] != x[XLEN-1]);

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 32
) (
    input  alu_pkg::alu_op_t op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    output logic [XLEN-1:0]  res,
    output logic             overflow
);
    localparam int SHW = $clog2(XLEN);

    logic            sub;
    logic [XLEN-1:0] sum;
    logic            add_ovf;
    logic [SHW-1:0]  shamt;

    assign shamt = b[SHW-1:0]; // low bits only

    // compare and not-equal reuse the subtractor
    assign sub = (op == alu_pkg::ALU_SUB) ||
                 (op == alu_pkg::ALU_SLT) ||
                 (op == alu_pkg::ALU_NE);

    add_sub_unit #(
        .XLEN     (XLEN)
    ) add_sub_i (
        .sub      (sub),
        .x        (a),
        .y        (b),
        .sum      (sum),
        .overflow (add_ovf)
    );

    always_comb begin
        res      = '0;
        overflow = 1'b0;
        case (op)
            alu_pkg::ALU_ADD: begin
                res      = sum;
                overflow = add_ovf;
            end
            alu_pkg::ALU_SUB: begin
                res      = sum;
                overflow = add_ovf;
            end
            alu_pkg::ALU_AND: res = a & b;
            alu_pkg::ALU_OR:  res = a | b;
            alu_pkg::ALU_XOR: res = a ^ b;
            alu_pkg::ALU_SLT: begin
                // signs differ: a negative means less
                if (a[XLEN-1] != b[XLEN-1])
                    res = XLEN'(a[XLEN-1]);
                else
                    res = XLEN'(sum[XLEN-1]);
            end
            alu_pkg::ALU_SLTU: res = XLEN'(a < b);
            alu_pkg::ALU_NE:   res = XLEN'(sum != '0);
            alu_pkg::ALU_SLL:  res = a << shamt;
            alu_pkg::ALU_SRL:  res = a >> shamt;
            alu_pkg::ALU_SRA:  res = $signed(a) >>> shamt; // sign fill
            default:           res = '0;
        endcase
    end

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

    // operation select, shared by decoder and alu
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5, // signed less-than
        ALU_SLTU = 4'd6,
        ALU_NE   = 4'd7, // 1 when operands differ
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_op_t;

    // what the output side does with the alu result
    typedef enum logic [1:0] {
        KIND_WB      = 2'd0, // register write
        KIND_BRANCH  = 2'd1, // branch resolve
        KIND_ILLEGAL = 2'd2  // bad encoding
    } res_kind_t;

endpackage

/* logic/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] pc,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [XLEN-1:0] wb_data,
    output logic            wb_overflow,
    output logic            br_valid,
    output logic            br_taken,
    output logic [XLEN-1:0] br_target,
    output logic            illegal
);
    typedef struct packed {
        alu_pkg::alu_op_t   op;
        logic               invert;
        alu_pkg::res_kind_t kind;
        logic [4:0]         rd;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    imm;
        logic               ovf_en;
    } exec_req_t;

    typedef struct packed {
        logic            wb_en;
        logic [4:0]      rd;
        logic [XLEN-1:0] wb_data;
        logic            overflow;
        logic            br_en;
        logic            br_taken;
        logic [XLEN-1:0] br_target;
        logic            illegal;
    } exec_rsp_t;

    logic            dec_valid;
    exec_req_t       dec_req;
    logic            req_valid;
    exec_req_t       req_q;
    logic [XLEN-1:0] alu_res;
    logic            alu_ovf;
    exec_rsp_t       rsp_d;
    logic            rsp_valid;
    exec_rsp_t       rsp_q;

    instr_decoder #(
        .XLEN        (XLEN),
        .REQ_T       (exec_req_t)
    ) decoder_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .req_valid   (dec_valid),
        .req         (dec_req)
    );

    pipe_reg #(
        .T         (exec_req_t)
    ) req_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dec_valid),
        .in_data   (dec_req),
        .out_valid (req_valid),
        .out_data  (req_q)
    );

    alu #(
        .XLEN     (XLEN)
    ) alu_i (
        .op       (req_q.op),
        .a        (req_q.a),
        .b        (req_q.b),
        .res      (alu_res),
        .overflow (alu_ovf)
    );

    result_select #(
        .XLEN         (XLEN),
        .REQ_T        (exec_req_t),
        .RSP_T        (exec_rsp_t)
    ) result_select_i (
        .req_valid    (req_valid),
        .req          (req_q),
        .alu_res      (alu_res),
        .alu_overflow (alu_ovf),
        .rsp          (rsp_d)
    );

    pipe_reg #(
        .T         (exec_rsp_t)
    ) rsp_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_data   (rsp_d),
        .out_valid (rsp_valid),
        .out_data  (rsp_q)
    );

    // strobes only live while the stage holds a valid response
    assign wb_valid    = rsp_valid & rsp_q.wb_en;
    assign wb_rd       = rsp_q.rd;
    assign wb_data     = rsp_q.wb_data;
    assign wb_overflow = wb_valid & rsp_q.overflow;
    assign br_valid    = rsp_valid & rsp_q.br_en;
    assign br_taken    = br_valid & rsp_q.br_taken;
    assign br_target   = rsp_q.br_target;
    assign illegal     = rsp_valid & rsp_q.illegal;

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder #(
    parameter int  XLEN  = 32,
    parameter type REQ_T = logic
) (
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] pc,
    output logic            req_valid,
    output REQ_T            req
);
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [XLEN-1:0]    imm_i;
    logic [XLEN-1:0]    imm_u;
    logic [XLEN-1:0]    imm_b;
    alu_pkg::alu_op_t   op;
    alu_pkg::res_kind_t kind;
    logic               invert;
    logic               ovf_en;
    logic               use_rs2;
    logic [XLEN-1:0]    opa;
    logic [XLEN-1:0]    imm;

    // funct3 to op for the unmodified (funct7 = 0) forms
    function automatic alu_pkg::alu_op_t base_op(input logic [2:0] f3);
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: return alu_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     return alu_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     return alu_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    return alu_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     return alu_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: return alu_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      return alu_pkg::ALU_OR;
            default:                return alu_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = instr[rv_isa_pkg::OPC_MSB:rv_isa_pkg::OPC_LSB];
    assign funct3 = instr[rv_isa_pkg::F3_MSB:rv_isa_pkg::F3_LSB];
    assign funct7 = instr[rv_isa_pkg::F7_MSB:rv_isa_pkg::F7_LSB];

    // sign-extended to XLEN
    assign imm_i = XLEN'($signed(instr[31:20]));
    assign imm_u = XLEN'($signed({instr[31:12], 12'h000}));
    assign imm_b = XLEN'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));

    always_comb begin
        op      = alu_pkg::ALU_ADD;
        kind    = alu_pkg::KIND_WB;
        invert  = 1'b0;
        ovf_en  = 1'b0;
        use_rs2 = 1'b0;
        opa     = rs1_data;
        imm     = imm_i;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                use_rs2 = 1'b1;
                if (funct7 == rv_isa_pkg::FUNCT7_BASE) begin
                    op     = base_op(funct3);
                    ovf_en = (funct3 == rv_isa_pkg::F3_ADD_SUB);
                end else if (funct7 == rv_isa_pkg::FUNCT7_ALT &&
                             funct3 == rv_isa_pkg::F3_ADD_SUB) begin
                    op     = alu_pkg::ALU_SUB;
                    ovf_en = 1'b1;
                end else if (funct7 == rv_isa_pkg::FUNCT7_ALT &&
                             funct3 == rv_isa_pkg::F3_SRL_SRA) begin
                    op = alu_pkg::ALU_SRA;
                end else begin
                    kind = alu_pkg::KIND_ILLEGAL;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                op     = base_op(funct3);
                ovf_en = (funct3 == rv_isa_pkg::F3_ADD_SUB); // addi only
                if (funct3 == rv_isa_pkg::F3_SLL && funct7 != rv_isa_pkg::FUNCT7_BASE)
                    kind = alu_pkg::KIND_ILLEGAL;
                if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
                    if (funct7 == rv_isa_pkg::FUNCT7_ALT)
                        op = alu_pkg::ALU_SRA;
                    else if (funct7 != rv_isa_pkg::FUNCT7_BASE)
                        kind = alu_pkg::KIND_ILLEGAL;
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                opa = '0;
                imm = imm_u;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                opa = pc;
                imm = imm_u;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                kind    = alu_pkg::KIND_BRANCH;
                use_rs2 = 1'b1;
                imm     = imm_b;
                case (funct3)
                    rv_isa_pkg::F3_BEQ: begin
                        op     = alu_pkg::ALU_NE;
                        invert = 1'b1;
                    end
                    rv_isa_pkg::F3_BNE:  op = alu_pkg::ALU_NE;
                    rv_isa_pkg::F3_BLT:  op = alu_pkg::ALU_SLT;
                    rv_isa_pkg::F3_BGE: begin
                        op     = alu_pkg::ALU_SLT;
                        invert = 1'b1;
                    end
                    rv_isa_pkg::F3_BLTU: op = alu_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_BGEU: begin
                        op     = alu_pkg::ALU_SLTU;
                        invert = 1'b1;
                    end
                    default: kind = alu_pkg::KIND_ILLEGAL; // funct3 010 / 011
                endcase
            end
            default: kind = alu_pkg::KIND_ILLEGAL;
        endcase
    end

    assign req_valid = instr_valid;

    always_comb begin
        req        = '0;
        req.op     = op;
        req.invert = invert;
        req.kind   = kind;
        req.rd     = instr[rv_isa_pkg::RD_MSB:rv_isa_pkg::RD_LSB];
        req.a      = opa;
        req.b      = use_rs2 ? rs2_data : imm;
        req.pc     = pc;
        req.imm    = imm;
        req.ovf_en = ovf_en;
    end

endmodule

/* logic/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            out_data <= in_data; // payload held between instructions
    end

endmodule

/* logic/result_select.sv */
`timescale 1ns/1ps

module result_select #(
    parameter int  XLEN  = 32,
    parameter type REQ_T = logic,
    parameter type RSP_T = logic
) (
    input  logic            req_valid,
    input  REQ_T            req,
    input  logic [XLEN-1:0] alu_res,
    input  logic            alu_overflow,
    output RSP_T            rsp
);
    logic [XLEN-1:0] target;

    assign target = req.pc + req.imm; // separate from the alu adder

    always_comb begin
        rsp           = '0;
        rsp.rd        = req.rd;
        rsp.wb_data   = alu_res;
        rsp.br_target = target;
        if (req_valid) begin
            case (req.kind)
                alu_pkg::KIND_WB: begin
                    rsp.wb_en    = (req.rd != 5'd0); // x0 writes dropped
                    rsp.overflow = req.ovf_en & alu_overflow;
                end
                alu_pkg::KIND_BRANCH: begin
                    rsp.br_en    = 1'b1;
                    rsp.br_taken = alu_res[0] ^ req.invert;
                end
                alu_pkg::KIND_ILLEGAL: rsp.illegal = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3, arithmetic group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3, branch group
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // sub / sra

    // instruction field positions
    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 6;
    localparam int RD_LSB  = 7;
    localparam int RD_MSB  = 11;
    localparam int F3_LSB  = 12;
    localparam int F3_MSB  = 14;
    localparam int F7_LSB  = 25;
    localparam int F7_MSB  = 31;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the exec_unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --top-module exec_unit_tb -f compile.f \
    -Mdir obj_dir -o exec_unit_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_unit_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$SIM_LOG"; then
    echo "No result line found in $SIM_LOG"
    exit 1
fi
exit 0

/* test/exec_unit_properties.sv */
`timescale 1ns/1ps

module exec_unit_properties (
    input logic        clk,
    input logic        rst,
    input logic        instr_valid,
    input logic [31:0] instr,
    input logic        wb_valid,
    input logic [4:0]  wb_rd,
    input logic        br_valid,
    input logic        illegal
);
    logic any_strobe;
    int   assert_errors = 0;

    assign any_strobe = wb_valid | br_valid | illegal;

    no_spurious_strobe: assert property (@(posedge clk) disable iff (rst)
        any_strobe |-> $past(instr_valid, 2))
        else begin
            $error("output strobe without an instruction two cycles earlier");
            assert_errors++;
        end

    // rd field nonzero means a strobe is always due
    strobe_latency: assert property (@(posedge clk) disable iff (rst)
        ($past(instr_valid, 2) && $past(instr[11:7], 2) != 5'd0) |-> any_strobe)
        else begin
            $error("accepted instruction produced no strobe after two cycles");
            assert_errors++;
        end

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({wb_valid, br_valid, illegal}))
        else begin
            $error("more than one output strobe high");
            assert_errors++;
        end

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_rd != 5'd0)
        else begin
            $error("write-back strobe for x0");
            assert_errors++;
        end

    strobes_clear_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !any_strobe)
        else begin
            $error("output strobe in the cycle after reset");
            assert_errors++;
        end

endmodule

bind exec_unit exec_unit_properties props_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .br_valid    (br_valid),
    .illegal     (illegal)
);

/* test/exec_unit_tb.sv */
`timescale 1ns/1ps

module exec_unit_tb;

    localparam int NUM_INSTR = 2000;
    localparam int DRAIN_LIMIT = 20;

    localparam logic [1:0] K_NONE = 2'd0; // write to x0, no strobe
    localparam logic [1:0] K_WB   = 2'd1;
    localparam logic [1:0] K_BR   = 2'd2;
    localparam logic [1:0] K_ILL  = 2'd3;

    typedef struct packed {
        logic [1:0]  kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        ovf;
        logic        taken;
        logic [31:0] target;
        int          due;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        wb_overflow;
    logic        br_valid;
    logic        br_taken;
    logic [31:0] br_target;
    logic        illegal;

    exp_t expected_q[$];
    exp_t e_drv;
    exp_t e_out;
    int   cycle = 0;
    int   value_errors = 0;
    int   other_errors = 0;
    int   n_sent = 0;
    int   n;
    int   wait_cnt;

    exec_unit #(
        .XLEN        (32)
    ) exec_unit_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_overflow (wb_overflow),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .illegal     (illegal)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Error: time %0t, %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // alu result per RV32I, ovf only meaningful for add/sub
    function automatic logic [32:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y,
                                          input logic [4:0] sh);
        logic [31:0] r;
        logic        v;
        v = 1'b0;
        case (f3)
            3'd0: begin
                r = alt ? x - y : x + y;
                if (alt)
                    v = (x[31] != y[31]) && (r[31] != x[31]);
                else
                    v = (x[31] == y[31]) && (r[31] != x[31]);
            end
            3'd1: r = x << sh;
            3'd2: r = {31'b0, $signed(x) < $signed(y)};
            3'd3: r = {31'b0, x < y};
            3'd4: r = x ^ y;
            3'd5: r = alt ? 32'($signed(x) >>> sh) : x >> sh;
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return {r, v};
    endfunction

    function automatic exp_t model_exec(input logic [31:0] ins, input logic [31:0] x,
                                        input logic [31:0] y, input logic [31:0] pcv);
        exp_t        e;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        e     = '0;
        e.kind = K_ILL;
        e.rd  = ins[11:7];
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        case (ins[6:0])
            rv_isa_pkg::OPC_OP: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    e.kind = K_WB;
                    {e.data, e.ovf} = arith(f3, f7[5], x, y, y[4:0]);
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
                    e.kind = K_WB;
                    {e.data, e.ovf} = arith(f3, f3 == 3'd5 && f7[5], x, imm_i, ins[24:20]);
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                e.kind = K_WB;
                e.data = imm_u;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                e.kind = K_WB;
                e.data = pcv + imm_u;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                e.kind   = K_BR;
                e.target = pcv + imm_b;
                case (f3)
                    3'd0: e.taken = (x == y);
                    3'd1: e.taken = (x != y);
                    3'd4: e.taken = ($signed(x) < $signed(y));
                    3'd5: e.taken = ($signed(x) >= $signed(y));
                    3'd6: e.taken = (x < y);
                    3'd7: e.taken = (x >= y);
                    default: e.kind = K_ILL;
                endcase
            end
            default: e.kind = K_ILL;
        endcase
        if (e.kind == K_WB && e.rd == 5'd0)
            e.kind = K_NONE;
        return e;
    endfunction

    // weighted mix of legal encodings, some bad funct7 and raw words
    function automatic logic [31:0] gen_instr();
        int         r;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        r   = int'($urandom_range(0, 99));
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        f3  = 3'($urandom);
        f7  = 7'h00;
        imm = 12'($urandom);
        if (r < 30) begin
            if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1)
                f7 = 7'h20;
            return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
        end
        if (r < 55) begin
            if (f3 == 3'd1)
                imm[11:5] = 7'h00;
            if (f3 == 3'd5)
                imm[11:5] = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
        end
        if (r < 62)
            return {20'($urandom), rd, rv_isa_pkg::OPC_LUI};
        if (r < 69)
            return {20'($urandom), rd, rv_isa_pkg::OPC_AUIPC};
        if (r < 90) begin
            f3 = 3'($urandom_range(0, 5));
            if (f3 >= 3'd2)
                f3 = f3 + 3'd2; // skip 010 and 011
            return {7'($urandom), rs2, rs1, f3, 5'($urandom), rv_isa_pkg::OPC_BRANCH};
        end
        if (r < 93) begin
            f7 = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h01;
            return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP}; // mostly bad funct7
        end
        if (r < 95) begin
            f3 = f3[2] ? 3'd5 : 3'd1; // slli / srli / srai
            return {7'h01, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
        end
        return $urandom;
    endfunction

    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 11))
            0: return 32'h0000_0000;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            3: return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    initial begin
        void'($urandom(32'hde40));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        pc          = '0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        for (n = 0; n < NUM_INSTR; n++) begin
            @(posedge clk);
            #1;
            instr_valid = ($urandom_range(0, 3) != 0); // random gaps
            instr       = gen_instr();
            rs1_data    = pick_operand();
            rs2_data    = pick_operand();
            pc          = $urandom & 32'hffff_fffc;
            if (instr_valid) begin
                n_sent++;
                e_drv     = model_exec(instr, rs1_data, rs2_data, pc);
                e_drv.due = cycle + 2; // one cycle per register stage
                if (e_drv.kind != K_NONE)
                    expected_q.push_back(e_drv);
            end
        end
        @(posedge clk);
        #1 instr_valid = 1'b0;
        wait_cnt = 0;
        while (expected_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (expected_q.size() != 0) begin
            other_errors++;
            $display("Timeout waiting for %0d outstanding results", expected_q.size());
        end else begin
            repeat (3) @(posedge clk);
        end
        $display("%0d instructions, %0d value errors, %0d other errors, %0d assertion errors",
                 n_sent, value_errors, other_errors, exec_unit_i.props_i.assert_errors);
        if (value_errors == 0 && other_errors == 0 &&
            exec_unit_i.props_i.assert_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (wb_valid || br_valid || illegal) begin
                if (expected_q.size() == 0) begin
                    other_errors++;
                    $display("Output strobe at time %0t with no instruction outstanding", $time);
                end else begin
                    e_out = expected_q.pop_front();
                    check_value("result cycle", 32'(e_out.due), 32'(cycle));
                    check_value("wb_valid", 32'(e_out.kind == K_WB), 32'(wb_valid));
                    check_value("br_valid", 32'(e_out.kind == K_BR), 32'(br_valid));
                    check_value("illegal", 32'(e_out.kind == K_ILL), 32'(illegal));
                    if (e_out.kind == K_WB) begin
                        check_value("wb_rd", 32'(e_out.rd), 32'(wb_rd));
                        check_value("wb_data", e_out.data, wb_data);
                        check_value("wb_overflow", 32'(e_out.ovf), 32'(wb_overflow));
                    end
                    if (e_out.kind == K_BR) begin
                        check_value("br_taken", 32'(e_out.taken), 32'(br_taken));
                        check_value("br_target", e_out.target, br_target);
                    end
                end
            end else if (expected_q.size() != 0 && expected_q[0].due <= cycle) begin
                other_errors++;
                $display("No output strobe at time %0t for a result due in cycle %0d",
                         $time, expected_q[0].due);
                void'(expected_q.pop_front());
            end
        end
    end

endmodule
